//--- source/issue_pkg.sv
package issue_pkg;

    ////////////////////////////////////////////////////
    // opcodes of the supported subset
    ////////////////////////////////////////////////////

    // 3R format, opcode in inst[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'b00000000000100000;
    localparam logic [16:0] OPC_SUB_W  = 17'b00000000000100010;
    localparam logic [16:0] OPC_AND    = 17'b00000000000101001;
    localparam logic [16:0] OPC_OR     = 17'b00000000000101010;

    // 2RI12 format, opcode in inst[31:22]
    localparam logic [9:0]  OPC_ADDI_W = 10'b0000001010;
    localparam logic [9:0]  OPC_ORI    = 10'b0000001110;
    localparam logic [9:0]  OPC_LD_W   = 10'b0010100010;
    localparam logic [9:0]  OPC_ST_W   = 10'b0010100110;

    ////////////////////////////////////////////////////
    // operation carried to execute
    ////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD     = 4'd0,
        ALU_SUB     = 4'd1,
        ALU_AND     = 4'd2,
        ALU_OR      = 4'd3,
        ALU_LOAD    = 4'd4,
        ALU_STORE   = 4'd5,
        ALU_ILLEGAL = 4'd15
    } alu_op_e;

    ////////////////////////////////////////////////////
    // instruction word, two views of the same 32 bits
    ////////////////////////////////////////////////////

    typedef struct packed {
        logic [16:0] opcode17;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode10;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
    } inst_word_u;

    // one decoded instruction as held in the issue buffer, 126 bits
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;      // sign-extended imm12, 0 for 3R
        alu_op_e     alu_op;
        logic [4:0]  rd;
        logic        rf_we;
        logic [4:0]  raddr1;
        logic [4:0]  raddr2;
        logic        is_mem;
        logic        illegal;
        logic [39:0] spare;    // reserved for execute fields
    } issue_entry_t;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import issue_pkg::*; (
    input  logic [31:0]  i_pc,
    input  logic [31:0]  i_inst,
    output issue_entry_t o_entry
);

    inst_word_u  word;
    logic [31:0] imm_sext;

    logic        hit_3r;
    alu_op_e     op_3r;
    logic        hit_2ri;
    alu_op_e     op_2ri;

    assign word     = i_inst;
    assign imm_sext = {{20{word.fmt_2ri12.imm12[11]}}, word.fmt_2ri12.imm12};

    ////////////////////////////////////////////////////
    // opcode match, 17-bit group first
    ////////////////////////////////////////////////////

    always_comb begin
        hit_3r = 1'b1;
        case (word.fmt_3r.opcode17)
            OPC_ADD_W: op_3r = ALU_ADD;
            OPC_SUB_W: op_3r = ALU_SUB;
            OPC_AND:   op_3r = ALU_AND;
            OPC_OR:    op_3r = ALU_OR;
            default: begin
                op_3r  = ALU_ILLEGAL;
                hit_3r = 1'b0;
            end
        endcase
    end

    always_comb begin
        hit_2ri = 1'b1;
        case (word.fmt_2ri12.opcode10)
            OPC_ADDI_W: op_2ri = ALU_ADD;
            OPC_ORI:    op_2ri = ALU_OR;
            OPC_LD_W:   op_2ri = ALU_LOAD;
            OPC_ST_W:   op_2ri = ALU_STORE;
            default: begin
                op_2ri  = ALU_ILLEGAL;
                hit_2ri = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////
    // build the entry
    ////////////////////////////////////////////////////

    always_comb begin
        o_entry    = '0;           // unused sources read r0
        o_entry.pc = i_pc;
        if (hit_3r) begin
            o_entry.alu_op = op_3r;
            o_entry.rd     = word.fmt_3r.rd;
            o_entry.rf_we  = 1'b1;
            o_entry.raddr1 = word.fmt_3r.rj;
            o_entry.raddr2 = word.fmt_3r.rk;
        end
        else if (hit_2ri) begin
            o_entry.alu_op = op_2ri;
            o_entry.imm    = imm_sext;
            o_entry.raddr1 = word.fmt_2ri12.rj;
            if (op_2ri == ALU_STORE) begin
                // store data comes from rd, nothing written back
                o_entry.raddr2 = word.fmt_2ri12.rd;
                o_entry.is_mem = 1'b1;
            end
            else begin
                o_entry.rd     = word.fmt_2ri12.rd;
                o_entry.rf_we  = 1'b1;
                o_entry.is_mem = (op_2ri == ALU_LOAD);
            end
        end
        else begin
            o_entry.alu_op  = ALU_ILLEGAL;
            o_entry.illegal = 1'b1;   // still flows through in order
        end
    end

endmodule

//--- source/issue_buffer.sv
`timescale 1ns/1ns

module issue_buffer import issue_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic         clk,
    input  logic         rstn,

    input  issue_entry_t i_entry_a,
    input  issue_entry_t i_entry_b,
    input  logic [1:0]   i_write_valid,
    input  logic         i_flush,
    input  logic [1:0]   i_issue_num,

    output issue_entry_t o_head_a,
    output issue_entry_t o_head_b,
    output logic [1:0]   o_head_valid,
    output logic         o_full
);

    localparam int AW = $clog2(DEPTH);

    issue_entry_t  mem [DEPTH];

    logic [AW-1:0] head;        // next slot to write
    logic [AW-1:0] tail;        // oldest entry
    logic [AW-1:0] head_p1;
    logic [AW-1:0] tail_p1;
    logic [AW:0]   count;       // occupancy, can reach DEPTH

    logic [1:0]    write_num;
    logic [AW:0]   count_left;  // after removals
    logic [AW:0]   count_next;  // after removals and writes

    assign head_p1 = head + 1'b1;
    assign tail_p1 = tail + 1'b1;

    // slot b only counts together with slot a
    assign write_num  = i_write_valid[1] ? (i_write_valid[0] ? 2'd2 : 2'd1) : 2'd0;
    assign count_left = count - (AW+1)'(i_issue_num);
    assign count_next = count_left + (AW+1)'(write_num);

    ////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end
        else if (!i_flush) begin    // fetches under flush are dropped
            if (write_num != 2'd0) begin
                mem[head] <= i_entry_a;
            end
            if (write_num == 2'd2) begin
                mem[head_p1] <= i_entry_b;
            end
        end
    end

    ////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else if (i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else begin
            head  <= head + AW'(write_num);
            tail  <= tail + AW'(i_issue_num);   // zero while stalled
            count <= count_next;
        end
    end

    // valid pair seen by the selector next cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_head_valid <= 2'b00;
        end
        else if (i_flush) begin
            o_head_valid <= 2'b00;
        end
        else begin
            case (count_next)
                '0:      o_head_valid <= 2'b00;
                (AW+1)'(1): o_head_valid <= 2'b10;
                default: o_head_valid <= 2'b11;
            endcase
        end
    end

    // keep a margin of 6 for the lag of the flag
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_full <= 1'b0;
        end
        else if (i_flush) begin
            o_full <= 1'b0;
        end
        else begin
            o_full <= (count_left >= (AW+1)'(DEPTH - 6));
        end
    end

    // two oldest entries, always presented
    assign o_head_a = mem[tail];
    assign o_head_b = mem[tail_p1];

endmodule

//--- source/dual_issue_select.sv
`timescale 1ns/1ns

module dual_issue_select import issue_pkg::*; (
    input  logic [1:0]   i_head_valid,
    input  issue_entry_t i_head_a,
    input  issue_entry_t i_head_b,
    input  logic         i_stall_dcache,
    input  logic         i_stall_div,

    output logic [1:0]   o_issue_num,
    output logic [1:0]   o_issue_valid
);

    logic stall;
    logic issue_a;
    logic raw_hazard;
    logic mem_pair;
    logic issue_b;

    assign stall = i_stall_dcache | i_stall_div;

    assign issue_a = i_head_valid[1] & ~stall;

    ////////////////////////////////////////////////////
    // pairing rules for slot b
    ////////////////////////////////////////////////////

    // b reads what a is about to write
    assign raw_hazard = i_head_a.rf_we && (i_head_a.rd != 5'd0) &&
                        ((i_head_b.raddr1 == i_head_a.rd) ||
                         (i_head_b.raddr2 == i_head_a.rd));

    assign mem_pair = i_head_a.is_mem & i_head_b.is_mem;   // one memory port

    assign issue_b = issue_a & i_head_valid[0] & ~raw_hazard & ~mem_pair;

    always_comb begin
        if (issue_b) begin
            o_issue_num   = 2'd2;
            o_issue_valid = 2'b11;
        end
        else if (issue_a) begin
            o_issue_num   = 2'd1;
            o_issue_valid = 2'b10;
        end
        else begin
            o_issue_num   = 2'd0;
            o_issue_valid = 2'b00;
        end
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic        rstn,

    input  logic [4:0]  i_raddr_a1,
    input  logic [4:0]  i_raddr_a2,
    input  logic [4:0]  i_raddr_b1,
    input  logic [4:0]  i_raddr_b2,
    output logic [31:0] o_rdata_a1,
    output logic [31:0] o_rdata_a2,
    output logic [31:0] o_rdata_b1,
    output logic [31:0] o_rdata_b2,

    input  logic        i_we,
    input  logic [4:0]  i_waddr,
    input  logic [31:0] i_wdata
);

    logic [31:0] regs [1:31];   // r0 has no storage

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_waddr != 5'd0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    ////////////////////////////////////////////////////
    // asynchronous reads, no write bypass
    ////////////////////////////////////////////////////

    assign o_rdata_a1 = (i_raddr_a1 == 5'd0) ? 32'd0 : regs[i_raddr_a1];
    assign o_rdata_a2 = (i_raddr_a2 == 5'd0) ? 32'd0 : regs[i_raddr_a2];
    assign o_rdata_b1 = (i_raddr_b1 == 5'd0) ? 32'd0 : regs[i_raddr_b1];
    assign o_rdata_b2 = (i_raddr_b2 == 5'd0) ? 32'd0 : regs[i_raddr_b2];

endmodule

//--- source/issue_stage_top.sv
`timescale 1ns/1ns

module issue_stage_top import issue_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic        clk,
    input  logic        rstn,

    // fetch side, bit 1 is the older slot
    input  logic [1:0]  i_fetch_valid,
    input  logic [31:0] i_fetch_pc_a,
    input  logic [31:0] i_fetch_inst_a,
    input  logic [31:0] i_fetch_pc_b,
    input  logic [31:0] i_fetch_inst_b,

    input  logic        i_flush,
    input  logic        i_stall_dcache,
    input  logic        i_stall_div,

    // write-back
    input  logic        i_wb_we,
    input  logic [4:0]  i_wb_addr,
    input  logic [31:0] i_wb_data,

    output logic        o_full,
    output logic [1:0]  o_issue_valid,

    output logic [31:0] o_issue_a_pc,
    output alu_op_e     o_issue_a_alu_op,
    output logic [4:0]  o_issue_a_rd,
    output logic        o_issue_a_rf_we,
    output logic [31:0] o_issue_a_imm,
    output logic        o_issue_a_illegal,
    output logic [31:0] o_issue_a_rdata1,
    output logic [31:0] o_issue_a_rdata2,

    output logic [31:0] o_issue_b_pc,
    output alu_op_e     o_issue_b_alu_op,
    output logic [4:0]  o_issue_b_rd,
    output logic        o_issue_b_rf_we,
    output logic [31:0] o_issue_b_imm,
    output logic        o_issue_b_illegal,
    output logic [31:0] o_issue_b_rdata1,
    output logic [31:0] o_issue_b_rdata2
);

    issue_entry_t entry_a;
    issue_entry_t entry_b;
    issue_entry_t head_a;
    issue_entry_t head_b;
    logic [1:0]   head_valid;
    logic [1:0]   issue_num;

    inst_decoder dec_a_i (
        .i_pc    (i_fetch_pc_a),
        .i_inst  (i_fetch_inst_a),
        .o_entry (entry_a)
    );

    inst_decoder dec_b_i (
        .i_pc    (i_fetch_pc_b),
        .i_inst  (i_fetch_inst_b),
        .o_entry (entry_b)
    );

    issue_buffer #(
        .DEPTH (DEPTH)
    ) buf_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_entry_a     (entry_a),
        .i_entry_b     (entry_b),
        .i_write_valid (i_fetch_valid),
        .i_flush       (i_flush),
        .i_issue_num   (issue_num),
        .o_head_a      (head_a),
        .o_head_b      (head_b),
        .o_head_valid  (head_valid),
        .o_full        (o_full)
    );

    dual_issue_select sel_i (
        .i_head_valid   (head_valid),
        .i_head_a       (head_a),
        .i_head_b       (head_b),
        .i_stall_dcache (i_stall_dcache),
        .i_stall_div    (i_stall_div),
        .o_issue_num    (issue_num),
        .o_issue_valid  (o_issue_valid)
    );

    // operands for both head entries
    reg_file rf_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_raddr_a1 (head_a.raddr1),
        .i_raddr_a2 (head_a.raddr2),
        .i_raddr_b1 (head_b.raddr1),
        .i_raddr_b2 (head_b.raddr2),
        .o_rdata_a1 (o_issue_a_rdata1),
        .o_rdata_a2 (o_issue_a_rdata2),
        .o_rdata_b1 (o_issue_b_rdata1),
        .o_rdata_b2 (o_issue_b_rdata2),
        .i_we       (i_wb_we),
        .i_waddr    (i_wb_addr),
        .i_wdata    (i_wb_data)
    );

    ////////////////////////////////////////////////////
    // head entry fields out to the ports
    ////////////////////////////////////////////////////

    assign o_issue_a_pc      = head_a.pc;
    assign o_issue_a_alu_op  = head_a.alu_op;
    assign o_issue_a_rd      = head_a.rd;
    assign o_issue_a_rf_we   = head_a.rf_we;
    assign o_issue_a_imm     = head_a.imm;
    assign o_issue_a_illegal = head_a.illegal;

    assign o_issue_b_pc      = head_b.pc;
    assign o_issue_b_alu_op  = head_b.alu_op;
    assign o_issue_b_rd      = head_b.rd;
    assign o_issue_b_rf_we   = head_b.rf_we;
    assign o_issue_b_imm     = head_b.imm;
    assign o_issue_b_illegal = head_b.illegal;

endmodule

//--- verification/issue_stage_checker.sv
`timescale 1ns/1ns

// slot vectors, msb first: pc(32) alu_op(4) rd(5) rf_we(1) imm(32) illegal(1) rdata1(32) rdata2(32)
module issue_stage_checker #(
    parameter int SAMPLE_NS = 3
) (
    input  logic         clk,
    input  logic         rstn,

    // as seen on the DUT ports
    input  logic [1:0]   i_act_valid,
    input  logic         i_act_full,
    input  logic [138:0] i_act_a,
    input  logic [138:0] i_act_b,

    // from the reference model
    input  logic [1:0]   i_exp_valid,
    input  logic         i_exp_full,
    input  logic [138:0] i_exp_a,
    input  logic [138:0] i_exp_b,

    output int           o_errors
);

    int errors = 0;

    assign o_errors = errors;

    task automatic compare_field(input string name, input logic [31:0] act,
                                 input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic compare_slot(input string s, input logic [138:0] act,
                                input logic [138:0] exp);
        compare_field({"o_issue_", s, "_pc"}, act[138:107], exp[138:107]);
        compare_field({"o_issue_", s, "_alu_op"}, 32'(act[106:103]), 32'(exp[106:103]));
        compare_field({"o_issue_", s, "_rd"}, 32'(act[102:98]), 32'(exp[102:98]));
        compare_field({"o_issue_", s, "_rf_we"}, 32'(act[97]), 32'(exp[97]));
        compare_field({"o_issue_", s, "_imm"}, act[96:65], exp[96:65]);
        compare_field({"o_issue_", s, "_illegal"}, 32'(act[64]), 32'(exp[64]));
        compare_field({"o_issue_", s, "_rdata1"}, act[63:32], exp[63:32]);
        compare_field({"o_issue_", s, "_rdata2"}, act[31:0], exp[31:0]);
    endtask

    //////////////////////////////////////////////////
    // sample late in the cycle, inputs settle at +1 ns
    //////////////////////////////////////////////////

    always begin
        @(posedge clk);
        #(SAMPLE_NS);
        if (rstn) begin
            compare_field("o_issue_valid", 32'(i_act_valid), 32'(i_exp_valid));
            compare_field("o_full", 32'(i_act_full), 32'(i_exp_full));
            if (i_exp_valid[1]) begin
                compare_slot("a", i_act_a, i_exp_a);
            end
            if (i_exp_valid[0]) begin   // slot b fields only matter when paired
                compare_slot("b", i_act_b, i_exp_b);
            end
        end
    end

endmodule

//--- verification/issue_stage_tb.sv
`timescale 1ns/1ns

module issue_stage_tb import issue_pkg::*; ();

    localparam int DEPTH        = 16;
    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_CYCLES = 8;
    localparam int CLK_PERIOD   = 4;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;

    logic         clk = 1'b0;
    logic         rstn;
    logic [1:0]   i_fetch_valid;
    logic [31:0]  i_fetch_pc_a, i_fetch_inst_a, i_fetch_pc_b, i_fetch_inst_b;
    logic         i_flush, i_stall_dcache, i_stall_div;
    logic         i_wb_we;
    logic [4:0]   i_wb_addr;
    logic [31:0]  i_wb_data;

    logic         o_full;
    logic [1:0]   o_issue_valid;
    logic [31:0]  o_issue_a_pc, o_issue_a_imm, o_issue_a_rdata1, o_issue_a_rdata2;
    logic [31:0]  o_issue_b_pc, o_issue_b_imm, o_issue_b_rdata1, o_issue_b_rdata2;
    alu_op_e      o_issue_a_alu_op, o_issue_b_alu_op;
    logic [4:0]   o_issue_a_rd, o_issue_b_rd;
    logic         o_issue_a_rf_we, o_issue_b_rf_we;
    logic         o_issue_a_illegal, o_issue_b_illegal;

    // reference model state
    issue_entry_t mq [$];
    logic [31:0]  mrf [32];
    logic         mfull;
    int           exp_num;
    logic [1:0]   exp_valid;
    logic [138:0] exp_a, exp_b, act_a, act_b;

    logic [31:0]  lfsr = 32'd32;
    logic [31:0]  next_pc;
    int           chk_errors;
    int           other_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    issue_stage_top #(.DEPTH(DEPTH)) dut_i (.*);

    assign act_a = {o_issue_a_pc, o_issue_a_alu_op, o_issue_a_rd, o_issue_a_rf_we,
                    o_issue_a_imm, o_issue_a_illegal, o_issue_a_rdata1, o_issue_a_rdata2};
    assign act_b = {o_issue_b_pc, o_issue_b_alu_op, o_issue_b_rd, o_issue_b_rf_we,
                    o_issue_b_imm, o_issue_b_illegal, o_issue_b_rdata1, o_issue_b_rdata2};

    issue_stage_checker chk_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_act_valid (o_issue_valid),
        .i_act_full  (o_full),
        .i_act_a     (act_a),
        .i_act_b     (act_b),
        .i_exp_valid (exp_valid),
        .i_exp_full  (mfull),
        .i_exp_a     (exp_a),
        .i_exp_b     (exp_b),
        .o_errors    (chk_errors)
    );

    //////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // registers from r0..r3 so hazards come often
    function automatic logic [31:0] make_inst();
        inst_word_u w;
        logic [2:0] kind;
        w = '0;
        if (take_bits(4) == 32'd0) begin
            return {10'h3ff, 22'(take_bits(22))};   // matches no opcode
        end
        kind = 3'(take_bits(3));
        if (kind < 3'd4) begin
            case (kind)
                3'd0:    w.fmt_3r.opcode17 = OPC_ADD_W;
                3'd1:    w.fmt_3r.opcode17 = OPC_SUB_W;
                3'd2:    w.fmt_3r.opcode17 = OPC_AND;
                default: w.fmt_3r.opcode17 = OPC_OR;
            endcase
            w.fmt_3r.rk = 5'(take_bits(2));
            w.fmt_3r.rj = 5'(take_bits(2));
            w.fmt_3r.rd = 5'(take_bits(2));
        end
        else begin
            case (kind)
                3'd4:    w.fmt_2ri12.opcode10 = OPC_ADDI_W;
                3'd5:    w.fmt_2ri12.opcode10 = OPC_ORI;
                3'd6:    w.fmt_2ri12.opcode10 = OPC_LD_W;
                default: w.fmt_2ri12.opcode10 = OPC_ST_W;
            endcase
            w.fmt_2ri12.imm12 = 12'(take_bits(12));
            w.fmt_2ri12.rj    = 5'(take_bits(2));
            w.fmt_2ri12.rd    = 5'(take_bits(2));
        end
        return w;
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic issue_entry_t model_decode(logic [31:0] pc, logic [31:0] inst);
        issue_entry_t e;
        logic         legal;
        e        = '0;
        e.pc     = pc;
        legal    = 1'b1;
        e.raddr1 = inst[9:5];   // rj sits at the same bits in both formats
        case (inst[31:15])
            OPC_ADD_W: e.alu_op = ALU_ADD;
            OPC_SUB_W: e.alu_op = ALU_SUB;
            OPC_AND:   e.alu_op = ALU_AND;
            OPC_OR:    e.alu_op = ALU_OR;
            default:   legal = 1'b0;
        endcase
        if (legal) begin
            e.raddr2 = inst[14:10];
            e.rd     = inst[4:0];
            e.rf_we  = 1'b1;
            return e;
        end
        legal = 1'b1;
        e.imm = {{20{inst[21]}}, inst[21:10]};
        case (inst[31:22])
            OPC_ADDI_W: e.alu_op = ALU_ADD;
            OPC_ORI:    e.alu_op = ALU_OR;
            OPC_LD_W: begin
                e.alu_op = ALU_LOAD;
                e.is_mem = 1'b1;
            end
            OPC_ST_W: begin
                e.alu_op = ALU_STORE;
                e.is_mem = 1'b1;
                e.raddr2 = inst[4:0];   // store data
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e         = '0;
            e.pc      = pc;
            e.alu_op  = ALU_ILLEGAL;
            e.illegal = 1'b1;
        end
        else if (e.alu_op != ALU_STORE) begin
            e.rd    = inst[4:0];
            e.rf_we = 1'b1;
        end
        return e;
    endfunction

    function automatic logic [138:0] slot_view(issue_entry_t e);
        return {e.pc, e.alu_op, e.rd, e.rf_we, e.imm, e.illegal, mrf[e.raddr1], mrf[e.raddr2]};
    endfunction

    // issue decision on the two oldest model entries
    task automatic compute_expected();
        issue_entry_t a;
        issue_entry_t b;
        logic         hazard;
        a         = '0;
        b         = '0;
        exp_valid = 2'b00;
        exp_num   = 0;
        if (!(i_stall_dcache || i_stall_div) && mq.size() >= 1) begin
            a         = mq[0];
            exp_valid = 2'b10;
            exp_num   = 1;
            if (mq.size() >= 2) begin
                b      = mq[1];
                hazard = a.rf_we && (a.rd != 5'd0) &&
                         ((b.raddr1 == a.rd) || (b.raddr2 == a.rd));
                if (!hazard && !(a.is_mem && b.is_mem)) begin
                    exp_valid = 2'b11;
                    exp_num   = 2;
                end
            end
        end
        exp_a = slot_view(a);
        exp_b = slot_view(b);
    endtask

    // state change at the clock edge from the inputs of the closing cycle
    task automatic model_edge();
        int left;
        if (i_wb_we && i_wb_addr != 5'd0) begin
            mrf[i_wb_addr] = i_wb_data;
        end
        if (i_flush) begin
            mq.delete();
            mfull = 1'b0;
        end
        else begin
            for (int i = 0; i < exp_num; i++) begin
                void'(mq.pop_front());
            end
            left  = mq.size();
            mfull = (left >= DEPTH - 6);
            if (i_fetch_valid[1]) begin
                mq.push_back(model_decode(i_fetch_pc_a, i_fetch_inst_a));
            end
            if (i_fetch_valid == 2'b11) begin
                mq.push_back(model_decode(i_fetch_pc_b, i_fetch_inst_b));
            end
            if (mq.size() > DEPTH) begin
                other_errors++;
                $display("%0t ns: more entries accepted than the buffer can hold", $time);
            end
        end
    endtask

    task automatic drive_inputs();
        int n;
        n = o_full ? 0 : int'(take_bits(2));   // hold fetches while full
        if (n == 3) begin
            n = 2;
        end
        i_fetch_valid  = (n == 0) ? 2'b00 : ((n == 1) ? 2'b10 : 2'b11);
        i_fetch_pc_a   = next_pc;
        i_fetch_inst_a = make_inst();
        i_fetch_pc_b   = next_pc + 32'd4;
        i_fetch_inst_b = make_inst();
        next_pc        = next_pc + 32'(4 * n);
        i_stall_dcache = (take_bits(3) == 32'd0);
        i_stall_div    = (take_bits(3) == 32'd0);
        i_flush        = (take_bits(7) == 32'd0);
        i_wb_we        = (take_bits(1) != 32'd0);
        i_wb_addr      = 5'(take_bits(2));
        i_wb_data      = take_bits(32);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rstn           = 1'b0;
        i_fetch_valid  = 2'b00;
        i_fetch_pc_a   = '0;
        i_fetch_inst_a = '0;
        i_fetch_pc_b   = '0;
        i_fetch_inst_b = '0;
        i_flush        = 1'b0;
        i_stall_dcache = 1'b0;
        i_stall_div    = 1'b0;
        i_wb_we        = 1'b0;
        i_wb_addr      = '0;
        i_wb_data      = '0;
        next_pc        = 32'h1c00_0000;
        mfull          = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mrf[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
        compute_expected();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_edge();
            #1;
            drive_inputs();
            compute_expected();
        end
        @(posedge clk);
        $display("error counts: %0d mismatches, %0d other failures", chk_errors, other_errors);
        if (chk_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog.f
source/issue_pkg.sv
source/inst_decoder.sv
source/issue_buffer.sv
source/dual_issue_select.sv
source/reg_file.sv
source/issue_stage_top.sv
verification/issue_stage_checker.sv
verification/issue_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the issue stage testbench with Verilator and run it
verilator --binary --timing -Wno-fatal --top-module issue_stage_tb -f verilog.f -o issue_sim \
    && ./obj_dir/issue_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
